/* src/csr_gen_pkg.sv */
`default_nettype none

package csr_gen_pkg;

    // ------------------------------------------------------------------
    // Index space
    // ------------------------------------------------------------------
    localparam int unsigned index_w = 32;

    typedef logic [index_w-1:0] csr_index_t;

    // Address shift amount of up to 31 bits
    typedef logic [4:0] shift_amt_t;

    // Outstanding requests at which issue stops
    localparam int unsigned pause_thresh = 8;

    // ------------------------------------------------------------------
    // Configuration
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [63:0] array_pointer;
        csr_index_t  index_start;
        csr_index_t  index_end;
        csr_index_t  stride;
        logic        shift_left;
        shift_amt_t  shift_amount;
    } csr_config_t;

    // Index sequencer FSM
    typedef enum logic [2:0] {
        IDLE,
        START,
        BUSY,
        PAUSE,
        FINISH
    } seq_state_t;

endpackage : csr_gen_pkg

`default_nettype wire

/* src/mem_packet_pkg.sv */
`default_nettype none

package mem_packet_pkg;

    // ------------------------------------------------------------------
    // Address
    // ------------------------------------------------------------------
    localparam int unsigned addr_w = 64;

    typedef logic [addr_w-1:0] mem_addr_t;

    // ------------------------------------------------------------------
    // Request packet
    // ------------------------------------------------------------------
    localparam int unsigned num_data_fields = 4;

    // Every field carries a copy of the edge index
    typedef struct packed {
        mem_addr_t                                      base;
        mem_addr_t                                      offset;
        csr_gen_pkg::csr_index_t [num_data_fields-1:0] field;
    } mem_request_t;

    // ------------------------------------------------------------------
    // Request queue
    // ------------------------------------------------------------------
    localparam int unsigned queue_depth = 16;
    localparam int unsigned queue_ptr_w = 4;

endpackage : mem_packet_pkg

`default_nettype wire

/* src/index_sequencer.sv */
`default_nettype none

module index_sequencer (
    input  wire                     ap_clk,
    input  wire                     areset_generator,
    input  wire                     start,
    input  wire csr_gen_pkg::csr_index_t index_start,
    input  wire csr_gen_pkg::csr_index_t index_end,
    input  wire csr_gen_pkg::csr_index_t stride,
    input  wire                     pause,
    output logic                    index_valid,
    output csr_gen_pkg::csr_index_t index,
    output logic                    issue_finished
);

    import csr_gen_pkg::*;

    // ------------------------------------------------------------------
    // Declarations
    // ------------------------------------------------------------------
    seq_state_t state_q;
    seq_state_t state_d;

    csr_index_t       count_q;
    logic [index_w:0] next_sum;
    logic             last_index;
    logic             issue;

    // ------------------------------------------------------------------
    // Stride counter
    // ------------------------------------------------------------------
    // Extra bit catches a wrap past the top of the index space
    assign next_sum   = {1'b0, count_q} + {1'b0, stride};
    assign last_index = next_sum >= {1'b0, index_end};

    // One index per cycle while pause is low
    assign issue = (state_q == BUSY) && !pause;

    always_ff @(posedge ap_clk) begin
        if (state_q == START) begin
            count_q <= index_start;
        end
        else if (issue && !last_index) begin
            count_q <= next_sum[index_w-1:0];
        end
    end

    // ------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state_q <= IDLE;
        end
        else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start) begin
                    state_d = START;
                end
            end
            START: begin
                // Empty range goes straight to the end
                if (index_start >= index_end) begin
                    state_d = FINISH;
                end
                else begin
                    state_d = BUSY;
                end
            end
            BUSY: begin
                if (pause) begin
                    state_d = PAUSE;
                end
                else if (last_index) begin
                    state_d = FINISH;
                end
            end
            PAUSE: begin
                if (!pause) begin
                    state_d = BUSY;
                end
            end
            FINISH: begin
                if (start) begin
                    state_d = START;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------
    assign index_valid    = issue;
    assign index          = count_q;
    assign issue_finished = (state_q == FINISH);

endmodule : index_sequencer

`default_nettype wire

/* src/pending_tally.sv */
`default_nettype none

module pending_tally (
    input  wire  ap_clk,
    input  wire  areset_generator,
    input  wire  issued,
    input  wire  popped,
    output logic pause,
    output logic tally_zero
);

    import csr_gen_pkg::*;
    import mem_packet_pkg::*;

    // Wide enough for a full queue
    logic [queue_ptr_w:0] count_q;

    // ------------------------------------------------------------------
    // Outstanding request count
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            count_q <= '0;
        end
        else begin
            case ({issued, popped})
                2'b10: count_q <= count_q + 1'b1;
                2'b01: count_q <= count_q - 1'b1;
                // Both or neither leave the count alone
                default: count_q <= count_q;
            endcase
        end
    end

    // Issue stops at the threshold so the queue cannot overflow
    assign pause      = (count_q >= pause_thresh);
    assign tally_zero = (count_q == '0);

endmodule : pending_tally

`default_nettype wire

/* src/request_emitter.sv */
`default_nettype none

module request_emitter (
    input  wire                          ap_clk,
    input  wire                          areset_generator,
    input  wire                          start,
    input  wire                          index_valid,
    input  wire csr_gen_pkg::csr_index_t      index,
    input  wire mem_packet_pkg::mem_addr_t    array_pointer,
    input  wire                          shift_left,
    input  wire csr_gen_pkg::shift_amt_t      shift_amount,
    input  wire                          issue_finished,
    input  wire                          tally_zero,
    input  wire                          request_pop,
    output logic                         pop_accepted,
    output logic                         request_valid,
    output mem_packet_pkg::mem_request_t request,
    output logic                         done
);

    import mem_packet_pkg::*;

    // ------------------------------------------------------------------
    // Declarations
    // ------------------------------------------------------------------
    mem_request_t packet_d;
    mem_request_t stage_packet;
    logic         stage_valid;

    mem_request_t queue_mem [queue_depth];

    logic [queue_ptr_w-1:0] wr_ptr;
    logic [queue_ptr_w-1:0] rd_ptr;
    logic [queue_ptr_w:0]   fill;

    // ------------------------------------------------------------------
    // Packet build
    // ------------------------------------------------------------------
    always_comb begin
        packet_d.base = array_pointer;
        // Widen before shifting so a left shift keeps the high bits
        if (shift_left) begin
            packet_d.offset = mem_addr_t'(index) << shift_amount;
        end
        else begin
            packet_d.offset = mem_addr_t'(index) >> shift_amount;
        end
        for (int i = 0; i < num_data_fields; i++) begin
            packet_d.field[i] = index;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            stage_valid <= 1'b0;
        end
        else begin
            stage_valid <= index_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        stage_packet <= packet_d;
    end

    // ------------------------------------------------------------------
    // Request queue
    // ------------------------------------------------------------------
    // Pops on an empty queue are dropped
    assign pop_accepted = request_pop && (fill != '0);

    always_ff @(posedge ap_clk) begin
        if (stage_valid) begin
            queue_mem[wr_ptr] <= stage_packet;
        end
        if (pop_accepted) begin
            request <= queue_mem[rd_ptr];
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            fill          <= '0;
            request_valid <= 1'b0;
        end
        else begin
            if (stage_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_accepted) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({stage_valid, pop_accepted})
                2'b10: fill <= fill + 1'b1;
                2'b01: fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            request_valid <= pop_accepted;
        end
    end

    // ------------------------------------------------------------------
    // Completion
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            done <= 1'b0;
        end
        else if (start) begin
            done <= 1'b0;
        end
        else if (issue_finished && tally_zero) begin
            done <= 1'b1;
        end
    end

endmodule : request_emitter

`default_nettype wire

/* src/csr_index_generator.sv */
`default_nettype none

module csr_index_generator (
    input  wire                          ap_clk,
    input  wire                          areset_generator,
    input  wire                          cfg_valid,
    input  wire csr_gen_pkg::csr_config_t     cfg,
    input  wire                          request_pop,
    output logic                         request_valid,
    output mem_packet_pkg::mem_request_t request,
    output logic                         busy,
    output logic                         done
);

    import csr_gen_pkg::*;

    // ------------------------------------------------------------------
    // Declarations
    // ------------------------------------------------------------------
    csr_config_t cfg_q;
    logic        accept;
    logic        start;
    logic        busy_q;
    logic        done_settled;

    logic       index_valid;
    csr_index_t index;
    logic       issue_finished;
    logic       pause;
    logic       tally_zero;
    logic       pop_accepted;

    // ------------------------------------------------------------------
    // Configuration and run control
    // ------------------------------------------------------------------
    assign accept = cfg_valid && !busy;

    always_ff @(posedge ap_clk) begin
        if (accept) begin
            cfg_q <= cfg;
        end
    end

    // Old done is still high while start is out
    assign done_settled = done && !start;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            start  <= 1'b0;
            busy_q <= 1'b0;
        end
        else begin
            start <= accept;
            if (accept) begin
                busy_q <= 1'b1;
            end
            else if (done_settled) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Drops in the same cycle done rises
    assign busy = busy_q && !done_settled;

    // ------------------------------------------------------------------
    // Submodules
    // ------------------------------------------------------------------
    index_sequencer u_index_sequencer (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start            (start),
        .index_start      (cfg_q.index_start),
        .index_end        (cfg_q.index_end),
        .stride           (cfg_q.stride),
        .pause            (pause),
        .index_valid      (index_valid),
        .index            (index),
        .issue_finished   (issue_finished)
    );

    pending_tally u_pending_tally (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .issued           (index_valid),
        .popped           (pop_accepted),
        .pause            (pause),
        .tally_zero       (tally_zero)
    );

    request_emitter u_request_emitter (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start            (start),
        .index_valid      (index_valid),
        .index            (index),
        .array_pointer    (cfg_q.array_pointer),
        .shift_left       (cfg_q.shift_left),
        .shift_amount     (cfg_q.shift_amount),
        .issue_finished   (issue_finished),
        .tally_zero       (tally_zero),
        .request_pop      (request_pop),
        .pop_accepted     (pop_accepted),
        .request_valid    (request_valid),
        .request          (request),
        .done             (done)
    );

endmodule : csr_index_generator

`default_nettype wire

/* testbench/tb_csr_index_generator.sv */
`default_nettype none

module tb_csr_index_generator;

    import csr_gen_pkg::*;
    import mem_packet_pkg::*;

    // Pops held back this long at the start of a case, so issue has to pause
    localparam int hold_cycles  = 40;
    localparam int case_timeout = 3000;
    localparam int drain_cycles = 6;

    logic         ap_clk;
    logic         areset_generator;
    logic         cfg_valid;
    csr_config_t  cfg;
    logic         request_pop;
    logic         request_valid;
    mem_request_t request;
    logic         busy;
    logic         done;

    logic [31:0] rng_state;
    int          error_count;
    int          case_count;
    int          failed_cases;
    logic        timed_out;

    csr_index_generator UUT (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .cfg_valid        (cfg_valid),
        .cfg              (cfg),
        .request_pop      (request_pop),
        .request_valid    (request_valid),
        .request          (request),
        .busy             (busy),
        .done             (done)
    );

    initial begin
        ap_clk = 1'b0;
        forever begin
            #2 ap_clk = ~ap_clk;
        end
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    // Outputs are settled one time unit after the edge
    task automatic next_cycle();
        @(posedge ap_clk);
        #1;
    endtask

    task automatic check_request(input csr_config_t c, input csr_index_t idx);
        logic [63:0] exp_offset;
        if (c.shift_left) begin
            exp_offset = {32'b0, idx} << c.shift_amount;
        end
        else begin
            exp_offset = {32'b0, idx} >> c.shift_amount;
        end
        check_value("request.base", request.base, c.array_pointer);
        check_value("request.offset", request.offset, exp_offset);
        for (int i = 0; i < num_data_fields; i++) begin
            check_value($sformatf("request.field[%0d]", i), request.field[i], idx);
        end
    endtask

    // ------------------------------------------------------------------
    // One configuration, from strobe to done
    // ------------------------------------------------------------------
    task automatic run_case(input int case_no, input csr_config_t c, input int exp_count);
        csr_config_t bogus;
        csr_index_t  exp_index;
        int          received;
        int          start_errors;
        int          cycle;
        logic        finished;

        start_errors = error_count;
        received = 0;
        exp_index = c.index_start;
        finished = 1'b0;
        // Would change every request if it were taken
        bogus = c;
        bogus.array_pointer = ~c.array_pointer;
        bogus.index_start = c.index_start + 1;

        cfg = c;
        cfg_valid = 1'b1;
        cycle = 0;
        while (!finished && cycle < case_timeout) begin
            next_cycle();
            if (cycle == 0) begin
                check_value("busy", busy, 1'b1);
            end
            if (request_valid) begin
                if (received >= exp_count) begin
                    $display("Case %0d: a request arrived beyond the expected %0d",
                             case_no, exp_count);
                    error_count++;
                end
                else begin
                    check_request(c, exp_index);
                    exp_index = exp_index + c.stride;
                end
                received++;
            end
            // Done from the previous run is still visible in cycle 0
            if (cycle > 0 && done) begin
                check_value("requests before done", received, exp_count);
                check_value("busy", busy, 1'b0);
                finished = 1'b1;
            end
            cfg_valid = 1'b0;
            if (cycle == 3 && busy) begin
                cfg = bogus;
                cfg_valid = 1'b1;
            end
            rng_state = next_random(rng_state);
            request_pop = (cycle >= hold_cycles) && rng_state[0];
            cycle++;
        end

        if (!finished) begin
            $display("Case %0d: timed out waiting for done", case_no);
            error_count++;
            timed_out = 1'b1;
        end
        else begin
            // Queue is empty now so pops must produce nothing
            request_pop = 1'b1;
            for (int i = 0; i < drain_cycles; i++) begin
                next_cycle();
                check_value("request_valid", request_valid, 1'b0);
                check_value("done", done, 1'b1);
            end
        end
        request_pop = 1'b0;

        if (error_count != start_errors) begin
            failed_cases++;
        end
        $display("Case %0d: %0d of %0d requests, %s", case_no, received, exp_count,
                 (error_count == start_errors) ? "ok" : "FAILED");
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        int          fd;
        int          fields;
        string       line;
        logic [63:0] ptr;
        logic [31:0] idx_start;
        logic [31:0] idx_end;
        logic [31:0] idx_stride;
        logic [31:0] left;
        logic [31:0] amount;
        logic [31:0] count;
        csr_config_t c;

        error_count = 0;
        case_count = 0;
        failed_cases = 0;
        timed_out = 1'b0;
        rng_state = 32'h2794;
        areset_generator = 1'b1;
        cfg_valid = 1'b0;
        cfg = '0;
        request_pop = 1'b0;

        repeat (5) @(posedge ap_clk);
        #1;
        areset_generator = 1'b0;
        check_value("request_valid", request_valid, 1'b0);
        check_value("busy", busy, 1'b0);
        check_value("done", done, 1'b0);

        fd = $fopen("testbench/csr_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file testbench/csr_cases.txt");
            error_count++;
        end
        else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                if (line.len() > 0 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%h %h %h %h %h %h %h", ptr, idx_start,
                                     idx_end, idx_stride, left, amount, count);
                    if (fields == 7) begin
                        c.array_pointer = ptr;
                        c.index_start = idx_start;
                        c.index_end = idx_end;
                        c.stride = idx_stride;
                        c.shift_left = left[0];
                        c.shift_amount = amount[4:0];
                        case_count++;
                        run_case(case_count, c, count);
                    end
                end
            end
            $fclose(fd);
        end
        if (case_count == 0) begin
            $display("No test cases were read from the case file");
            error_count++;
        end

        $display("Cases run: %0d, cases failed: %0d, errors: %0d",
                 case_count, failed_cases, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end
        else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule : tb_csr_index_generator

`default_nettype wire

/* build.f */
src/csr_gen_pkg.sv
src/mem_packet_pkg.sv
src/index_sequencer.sv
src/pending_tally.sv
src/request_emitter.sv
src/csr_index_generator.sv
testbench/tb_csr_index_generator.sv

/* Bender.yml */
package:
  name: csr_index_generator

sources:
  - src/csr_gen_pkg.sv
  - src/mem_packet_pkg.sv
  - src/index_sequencer.sv
  - src/pending_tally.sv
  - src/request_emitter.sv
  - src/csr_index_generator.sv
  - target: simulation
    files:
      - testbench/tb_csr_index_generator.sv

/* testbench/csr_cases.txt */
# array_pointer index_start index_end stride shift_left shift_amount expected_count
# All columns in hex, one test per line
0000000010000000 00000000 0000000a 00000001 1 02 0a
0000004000000000 00000005 00000040 00000003 1 03 14
ffff000000000000 00000100 00000100 00000001 1 04 00
123456789abcdef0 00000020 00000010 00000002 0 01 00
0000000008000000 00001000 00001028 00000004 0 01 0a
8000000000000000 fffffff0 ffffffff 00000005 1 1f 03
0000000100000000 00000007 00000008 00000010 0 00 01
00000000dead0000 00000000 00000030 00000001 1 04 30
0000000000001000 fffffff0 ffffffff 80000000 0 08 01
